// File: Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - common/mips_pkg.sv
      - logic/alu.sv
      - logic/branch_judge.sv
      - muldiv/muldiv.sv
      - logic/exec_unit.sv
      - logic/exec_stage.sv
  - target: simulation
    files:
      - tb/exec_stage_assert.sv
      - tb/exec_stage_tb.sv

// File: common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and latencies
    ////////////////////////////////////////////////////////////////////////////

    localparam int data_width  = 32;  // One machine word
    localparam int shamt_width = 5;   // Shift amount field of an R-type instruction

    // Edges from the start edge until done rises
    localparam int mul_cycles = 4;
    localparam int div_cycles = 33;   // 32 shift-subtract steps and the sign fix

    ////////////////////////////////////////////////////////////////////////////
    // Decoded control fields
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ADD  = 4'd0,   // Signed add, traps on overflow
        ADDU = 4'd1,
        SUB  = 4'd2,   // Signed subtract, traps on overflow
        SUBU = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        NOR  = 4'd7,
        SLT  = 4'd8,   // Set on signed less than
        SLTU = 4'd9,
        SLL  = 4'd10,
        SRL  = 4'd11,
        SRA  = 4'd12,
        LUI  = 4'd13   // Immediate into the upper half
    } alu_func_t;

    typedef enum logic [2:0] {
        NONE = 3'd0,   // Not a branch
        EQ   = 3'd1,
        NE   = 3'd2,
        GEZ  = 3'd3,
        GTZ  = 3'd4,
        LEZ  = 3'd5,
        LTZ  = 3'd6
    } branch_type_t;

    typedef enum logic [3:0] {
        MD_NONE = 4'd0,
        MULT    = 4'd1,
        MULTU   = 4'd2,
        DIV     = 4'd3,
        DIVU    = 4'd4,
        MTHI    = 4'd5,
        MTLO    = 4'd6,
        MFHI    = 4'd7,   // Reads HI, does not start the unit
        MFLO    = 4'd8
    } md_op_t;

endpackage

`default_nettype wire

// File: exec_stage.f
common/mips_pkg.sv
logic/alu.sv
logic/branch_judge.sv
muldiv/muldiv.sv
logic/exec_unit.sv
logic/exec_stage.sv
tb/exec_stage_assert.sv
tb/exec_stage_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic [mips_pkg::data_width-1:0] a,
    input  wire logic [mips_pkg::data_width-1:0] b,
    input  mips_pkg::alu_func_t                  func,
    output logic      [mips_pkg::data_width-1:0] y,
    output logic                                 overflow
);

    import mips_pkg::*;

    logic [data_width-1:0]  sum;
    logic [data_width-1:0]  diff;
    logic [shamt_width-1:0] sa;
    logic                   add_ovf;
    logic                   sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;
    assign sa   = a[shamt_width-1:0];  // Shift amount comes from operand A

    // Same operand signs but the sum's sign differs
    assign add_ovf = (a[data_width-1] == b[data_width-1]) &&
                     (sum[data_width-1] != a[data_width-1]);
    // Operand signs differ and the result took the sign of b
    assign sub_ovf = (a[data_width-1] != b[data_width-1]) &&
                     (diff[data_width-1] != a[data_width-1]);

    always_comb begin
        y = '0;
        case (func)
            ADD, ADDU: y = sum;
            SUB, SUBU: y = diff;
            AND:       y = a & b;
            OR:        y = a | b;
            XOR:       y = a ^ b;
            NOR:       y = ~(a | b);
            SLT:       y = {{(data_width-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:      y = {{(data_width-1){1'b0}}, a < b};
            SLL:       y = b << sa;
            SRL:       y = b >> sa;
            SRA:       y = $signed(b) >>> sa;  // Sign bit fills from the left
            LUI:       y = {b[data_width/2-1:0], {(data_width/2){1'b0}}};
            default:   y = '0;
        endcase
    end

    // Only the trapping forms report overflow
    always_comb begin
        case (func)
            ADD:     overflow = add_ovf;
            SUB:     overflow = sub_ovf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/branch_judge.sv
`timescale 1ns/1ps
`default_nettype none

module branch_judge (
    input  wire logic [mips_pkg::data_width-1:0] a,
    input  wire logic [mips_pkg::data_width-1:0] b,
    input  mips_pkg::branch_type_t               branch_type,
    output logic                                 taken
);

    import mips_pkg::*;

    logic a_neg;
    logic a_zero;

    assign a_neg  = a[data_width-1];
    assign a_zero = (a == '0);

    // The zero-compare branches look at operand A alone
    always_comb begin
        case (branch_type)
            EQ:      taken = (a == b);
            NE:      taken = (a != b);
            GEZ:     taken = !a_neg;
            GTZ:     taken = !a_neg && !a_zero;
            LEZ:     taken = a_neg || a_zero;
            LTZ:     taken = a_neg;
            default: taken = 1'b0;  // NONE never redirects fetch
        endcase
    end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic [mips_pkg::data_width-1:0]  srca,
    input  wire logic [mips_pkg::data_width-1:0]  srcb,
    input  wire logic [mips_pkg::data_width-1:0]  imm,
    input  wire logic [mips_pkg::shamt_width-1:0] shamt,
    input  wire logic                             shamt_valid,
    input  wire logic                             use_imm,
    input  mips_pkg::alu_func_t                   alu_func,
    input  mips_pkg::branch_type_t                branch_type,
    input  mips_pkg::md_op_t                      md_op,
    input  wire logic                             is_link,
    input  wire logic [mips_pkg::data_width-1:0]  pcplus4,
    input  wire logic                             first_cycle,
    input  wire logic                             flush,
    output logic      [mips_pkg::data_width-1:0]  result,
    output logic                                  taken,
    output logic                                  overflow,
    output logic      [mips_pkg::data_width-1:0]  hi,
    output logic      [mips_pkg::data_width-1:0]  lo,
    output logic                                  finish
);

    import mips_pkg::*;

    logic                  md_start;
    md_op_t                md_op_start;
    logic [data_width-1:0] md_a, md_b;
    logic                  md_done;

    exec_unit u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .srca        (srca),
        .srcb        (srcb),
        .imm         (imm),
        .shamt       (shamt),
        .shamt_valid (shamt_valid),
        .use_imm     (use_imm),
        .alu_func    (alu_func),
        .branch_type (branch_type),
        .md_op       (md_op),
        .is_link     (is_link),
        .pcplus4     (pcplus4),
        .first_cycle (first_cycle),
        .flush       (flush),
        .hi          (hi),
        .lo          (lo),
        .md_done     (md_done),
        .result      (result),
        .taken       (taken),
        .overflow    (overflow),
        .finish      (finish),
        .md_start    (md_start),
        .md_op_start (md_op_start),
        .md_a        (md_a),
        .md_b        (md_b)
    );

    muldiv u_muldiv (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .start (md_start),
        .op    (md_op_start),
        .a     (md_a),
        .b     (md_b),
        .hi    (hi),
        .lo    (lo),
        .done  (md_done)
    );

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic [mips_pkg::data_width-1:0]  srca,
    input  wire logic [mips_pkg::data_width-1:0]  srcb,
    input  wire logic [mips_pkg::data_width-1:0]  imm,
    input  wire logic [mips_pkg::shamt_width-1:0] shamt,
    input  wire logic                             shamt_valid,
    input  wire logic                             use_imm,
    input  mips_pkg::alu_func_t                   alu_func,
    input  mips_pkg::branch_type_t                branch_type,
    input  mips_pkg::md_op_t                      md_op,
    input  wire logic                             is_link,
    input  wire logic [mips_pkg::data_width-1:0]  pcplus4,
    input  wire logic                             first_cycle,
    input  wire logic                             flush,
    input  wire logic [mips_pkg::data_width-1:0]  hi,
    input  wire logic [mips_pkg::data_width-1:0]  lo,
    input  wire logic                             md_done,
    output logic      [mips_pkg::data_width-1:0]  result,
    output logic                                  taken,
    output logic                                  overflow,
    output logic                                  finish,
    output logic                                  md_start,
    output mips_pkg::md_op_t                      md_op_start,
    output logic      [mips_pkg::data_width-1:0]  md_a,
    output logic      [mips_pkg::data_width-1:0]  md_b
);

    import mips_pkg::*;

    logic [data_width-1:0] op_a, op_b;
    logic [data_width-1:0] alu_y;
    logic [data_width-1:0] pcplus8;
    logic                  alu_ovf;
    logic                  md_busy_op;

    assign op_a = shamt_valid ? data_width'(shamt) : srca;  // Zero-extended shift amount
    assign op_b = use_imm ? imm : srcb;

    alu u_alu (
        .a        (op_a),
        .b        (op_b),
        .func     (alu_func),
        .y        (alu_y),
        .overflow (alu_ovf)
    );

    // Branches always compare the register operands
    branch_judge u_branch (
        .a           (srca),
        .b           (srcb),
        .branch_type (branch_type),
        .taken       (taken)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Multiply/divide hand-off and result select
    ////////////////////////////////////////////////////////////////////////////

    // Operations that must wait for the unit before the stage can move on
    assign md_busy_op = (md_op == MULT) || (md_op == MULTU) || (md_op == DIV) ||
                        (md_op == DIVU) || (md_op == MTHI)  || (md_op == MTLO);

    assign md_start    = first_cycle && md_busy_op && !flush;
    assign md_op_start = md_op;
    assign md_a        = op_a;
    assign md_b        = op_b;

    // The first cycle masks a done left over from the previous operation
    assign finish = md_busy_op ? (md_done && !first_cycle) : 1'b1;

    assign pcplus8 = pcplus4 + data_width'(4);  // Return address skips the delay slot

    assign result = is_link         ? pcplus8 :
                    (md_op == MFHI) ? hi      :
                    (md_op == MFLO) ? lo      : alu_y;

    assign overflow = (md_op == MD_NONE) ? alu_ovf : 1'b0;

endmodule

`default_nettype wire

// File: muldiv/muldiv.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            flush,
    input  wire logic                            start,
    input  mips_pkg::md_op_t                     op,
    input  wire logic [mips_pkg::data_width-1:0] a,
    input  wire logic [mips_pkg::data_width-1:0] b,
    output logic      [mips_pkg::data_width-1:0] hi,
    output logic      [mips_pkg::data_width-1:0] lo,
    output logic                                 done
);

    import mips_pkg::*;

    // The local DIV state hides the divide opcode of the package
    typedef enum logic [1:0] {IDLE, MUL, DIV, FIX} state_t;
    typedef logic [$clog2(div_cycles)-1:0] cnt_t;

    state_t                  state;
    cnt_t                    cnt;
    md_op_t                  op_q;
    logic [2*data_width-1:0] prod;
    logic [data_width-1:0]   rem, quo, dvs;
    logic                    quo_neg, rem_neg;
    logic                    div_signed;
    logic [data_width-1:0]   a_mag, b_mag;
    logic [data_width+1:0]   trial;

    assign div_signed = (op == mips_pkg::DIV);
    assign a_mag      = (div_signed && a[data_width-1]) ? -a : a;
    assign b_mag      = (div_signed && b[data_width-1]) ? -b : b;
    // Shift in the next dividend bit and try to subtract the divisor
    assign trial      = {1'b0, rem, quo[data_width-1]} - {2'b00, dvs};

    ////////////////////////////////////////////////////////////////////////////
    // Control and HI/LO
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
            done  <= 1'b0;
            hi    <= '0;
            lo    <= '0;
        end else if (flush) begin
            state <= IDLE;  // HI and LO keep their old values
            done  <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
            case (op)
                MULT, MULTU: begin
                    state <= MUL;
                    cnt   <= cnt_t'(mul_cycles - 1);
                end
                mips_pkg::DIV, DIVU: begin
                    state <= DIV;
                    cnt   <= cnt_t'(div_cycles - 2);  // Last step hands over to FIX
                end
                MTHI, MTLO: begin
                    if (op == MTHI) hi <= a;
                    else            lo <= a;
                    state <= MUL;   // One wait cycle, then done
                    cnt   <= '0;
                end
                default: state <= IDLE;
            endcase
        end else begin
            case (state)
                MUL: begin
                    if (cnt == '0) begin
                        if (op_q == MULT || op_q == MULTU) {hi, lo} <= prod;
                        done  <= 1'b1;
                        state <= IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                DIV: begin
                    if (cnt == '0) state <= FIX;
                    else           cnt   <= cnt - 1'b1;
                end
                FIX: begin
                    lo    <= quo_neg ? -quo : quo;
                    hi    <= rem_neg ? -rem : rem;  // Remainder follows the dividend sign
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            op_q    <= op;
            if (op == MULT) prod <= $signed(a) * $signed(b);
            else            prod <= a * b;
            rem     <= '0;
            quo     <= a_mag;  // Quotient bits shift in as the dividend shifts out
            dvs     <= b_mag;
            quo_neg <= div_signed && (a[data_width-1] ^ b[data_width-1]);
            rem_neg <= div_signed && a[data_width-1];
        end else if (state == DIV) begin
            if (!trial[data_width+1]) begin
                rem <= trial[data_width-1:0];
                quo <= {quo[data_width-2:0], 1'b1};
            end else begin
                rem <= {rem[data_width-2:0], quo[data_width-1]};
                quo <= {quo[data_width-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/exec_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_assert (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic flush,
    input wire logic md_start,
    input wire logic md_done
);

    int fails = 0;  // Failed assertions so far

    // A start clears the done left over from the previous operation
    a_start_done: assert property (@(posedge clk) disable iff (!rst_n)
        md_start |=> !md_done)
        else begin
            $error("md_done still high the edge after a start");
            fails++;
        end

    a_flush_done: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !md_done)
        else begin
            $error("md_done still high the edge after a flush");
            fails++;
        end

    // Done is a level that holds until the next start or flush
    a_done_held: assert property (@(posedge clk) disable iff (!rst_n)
        (md_done && !md_start && !flush) |=> md_done)
        else begin
            $error("md_done dropped without a start or a flush");
            fails++;
        end

endmodule

bind exec_stage exec_stage_assert u_assert (
    .clk (clk), .rst_n (rst_n), .flush (flush), .md_start (md_start), .md_done (md_done)
);

`default_nettype wire

// File: tb/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb;

    import mips_pkg::*;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int num_instr    = 400;
    localparam int wait_limit   = div_cycles + 4;  // Longest wait for finish in edges

    logic                   clk, rst_n;
    logic [data_width-1:0]  srca, srcb, imm, pcplus4;
    logic [shamt_width-1:0] shamt;
    logic                   shamt_valid, use_imm, is_link, first_cycle, flush;
    alu_func_t              alu_func;
    branch_type_t           branch_type;
    md_op_t                 md_op;
    logic [data_width-1:0]  result, hi, lo;
    logic                   taken, overflow, finish;

    integer                 seed;
    int                     errors;
    int                     checks;
    logic [data_width-1:0]  m_hi, m_lo;  // Model copies of HI and LO

    exec_stage uut (
        .clk (clk), .rst_n (rst_n), .srca (srca), .srcb (srcb), .imm (imm), .shamt (shamt),
        .shamt_valid (shamt_valid), .use_imm (use_imm), .alu_func (alu_func),
        .branch_type (branch_type), .md_op (md_op), .is_link (is_link), .pcplus4 (pcplus4),
        .first_cycle (first_cycle), .flush (flush), .result (result), .taken (taken),
        .overflow (overflow), .hi (hi), .lo (lo), .finish (finish)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((num_instr * wait_limit + reset_cycles + 10) * clk_period);
        $display("Timeout: the run did not complete in the expected number of cycles");
        $display("Checks failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Returns the overflow flag above the 32-bit result
    function automatic logic [32:0] alu_model(input alu_func_t f, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [32:0] s;
        logic [4:0]  sh;
        sh = a[4:0];
        case (f)
            ADD: begin
                s = {a[31], a} + {b[31], b};
                return {s[32] ^ s[31], s[31:0]};
            end
            SUB: begin
                s = {a[31], a} - {b[31], b};
                return {s[32] ^ s[31], s[31:0]};
            end
            ADDU:    return {1'b0, a + b};
            SUBU:    return {1'b0, a - b};
            AND:     return {1'b0, a & b};
            OR:      return {1'b0, a | b};
            XOR:     return {1'b0, a ^ b};
            NOR:     return {1'b0, ~(a | b)};
            SLT:     return ($signed(a) < $signed(b)) ? 33'd1 : 33'd0;
            SLTU:    return (a < b) ? 33'd1 : 33'd0;
            SLL:     return {1'b0, b << sh};
            SRL:     return {1'b0, b >> sh};
            SRA:     return {1'b0, (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0)};
            LUI:     return {1'b0, b[15:0], 16'h0};
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_model(input branch_type_t bt, input logic [31:0] a,
                                          input logic [31:0] b);
        case (bt)
            EQ:      return a == b;
            NE:      return a != b;
            GEZ:     return $signed(a) >= 0;
            GTZ:     return $signed(a) > 0;
            LEZ:     return $signed(a) <= 0;
            LTZ:     return $signed(a) < 0;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue(input alu_func_t f, input branch_type_t bt, input md_op_t op,
                         input logic [31:0] a, input logic [31:0] b, input logic [31:0] im,
                         input logic [4:0] sh, input logic sv, input logic ui,
                         input logic lk, input logic [31:0] pc);
        @(posedge clk);
        alu_func    <= f;
        branch_type <= bt;
        md_op       <= op;
        srca        <= a;
        srcb        <= b;
        imm         <= im;
        shamt       <= sh;
        shamt_valid <= sv;
        use_imm     <= ui;
        is_link     <= lk;
        pcplus4     <= pc;
        first_cycle <= 1'b1;  // Every new instruction opens with its first cycle
    endtask

    task automatic read_hilo();
        issue(ADD, NONE, MFHI, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0, '0);
        #1;
        check_value("result (MFHI)", result, m_hi);
        check_value("finish (MFHI)", finish, 1'b1);
        issue(ADD, NONE, MFLO, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0, '0);
        #1;
        check_value("result (MFLO)", result, m_lo);
        check_value("finish (MFLO)", finish, 1'b1);
    endtask

    task automatic run_alu();
        alu_func_t    f;
        branch_type_t bt;
        logic [31:0]  ra, rb, im, pc, a_op, b_op, exp_y;
        logic [4:0]   sh;
        logic         sv, ui, lk;
        logic [32:0]  m;
        f  = alu_func_t'($unsigned($random(seed)) % 14);
        bt = branch_type_t'($unsigned($random(seed)) % 7);
        ra = $random(seed);
        if (($random(seed) & 7) == 0) ra = '0;  // Zero operand for the zero-compare branches
        rb = (($random(seed) & 3) == 0) ? ra : $random(seed);  // Equal pairs for EQ and NE
        im = $random(seed);
        sh = $random(seed);
        sv = $random(seed);
        ui = $random(seed);
        lk = ($random(seed) & 3) == 0;
        pc = $random(seed) & 32'hffff_fffc;
        a_op  = sv ? {27'b0, sh} : ra;
        b_op  = ui ? im : rb;
        m     = alu_model(f, a_op, b_op);
        exp_y = lk ? pc + 32'd4 : m[31:0];  // Return address is two words past the branch
        issue(f, bt, MD_NONE, ra, rb, im, sh, sv, ui, lk, pc);
        #1;
        check_value("result", result, exp_y);
        check_value("overflow", overflow, m[32]);
        check_value("taken", taken, branch_model(bt, ra, rb));
        check_value("finish", finish, 1'b1);
    endtask

    // A flush_after of -1 lets the operation complete
    task automatic run_md(input md_op_t op, input logic [31:0] a, input logic [31:0] b,
                          input int flush_after);
        longint      na, nb;
        logic [63:0] p, q, r;
        int          n, expect_n;
        issue(ADD, NONE, op, a, b, '0, '0, 1'b0, 1'b0, 1'b0, '0);
        #1;
        check_value("finish (first cycle)", finish, 1'b0);
        check_value("overflow (muldiv)", overflow, 1'b0);
        @(posedge clk);
        first_cycle <= 1'b0;
        if (flush_after >= 0) begin
            repeat (flush_after) @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            #1;
            check_value("finish (flushed)", finish, 1'b0);
            @(posedge clk);
            #1;
            check_value("finish (flushed)", finish, 1'b0);
        end else begin
            expect_n = (op == MULT || op == MULTU) ? mul_cycles :
                       (op == DIV || op == DIVU)   ? div_cycles : 1;
            na = (op == MULT || op == DIV) ? longint'($signed(a)) : longint'({32'b0, a});
            nb = (op == MULT || op == DIV) ? longint'($signed(b)) : longint'({32'b0, b});
            case (op)
                MULT, MULTU: begin
                    p    = na * nb;
                    m_hi = p[63:32];
                    m_lo = p[31:0];
                end
                DIV, DIVU: begin
                    q    = na / nb;
                    r    = na % nb;
                    m_hi = r[31:0];
                    m_lo = q[31:0];
                end
                MTHI:    m_hi = a;
                default: m_lo = a;
            endcase
            n = 0;
            #1;
            while (!finish && n < wait_limit) begin
                @(posedge clk);
                n++;
                #1;
            end
            if (!finish) begin
                errors++;
                $display("Error: finish never rose for %s", op.name());
            end else begin
                check_value("latency", n, expect_n);
            end
        end
        check_value("hi", hi, m_hi);
        check_value("lo", lo, m_lo);
        read_hilo();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          cls;
        logic [31:0] ra, rb;
        md_op_t      op;
        seed = 32'h115b;
        errors = 0;
        checks = 0;
        m_hi = '0;
        m_lo = '0;
        rst_n = 1'b0;
        srca = '0;
        srcb = '0;
        imm = '0;
        pcplus4 = '0;
        shamt = '0;
        shamt_valid = 1'b0;
        use_imm = 1'b0;
        is_link = 1'b0;
        first_cycle = 1'b0;
        flush = 1'b0;
        alu_func = ADD;
        branch_type = NONE;
        md_op = MD_NONE;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        #1;
        check_value("hi (reset)", hi, '0);
        check_value("lo (reset)", lo, '0);
        for (int i = 0; i < num_instr; i++) begin
            cls = $unsigned($random(seed)) % 16;
            ra  = $random(seed);
            rb  = $random(seed);
            if ($random(seed) & 1) rb = rb & 32'hff;  // Small divisors give larger quotients
            if (rb == '0) rb = 32'd1;
            if (cls < 8) begin
                run_alu();
            end else if (cls < 10) begin
                run_md(($random(seed) & 1) ? MULT : MULTU, ra, rb, -1);
            end else if (cls < 12) begin
                run_md(($random(seed) & 1) ? DIV : DIVU, ra, rb, -1);
            end else if (cls == 12) begin
                run_md(($random(seed) & 1) ? MTHI : MTLO, ra, rb, -1);
            end else if (cls == 13) begin
                read_hilo();
            end else begin
                op = md_op_t'(MULT + $unsigned($random(seed)) % 4);
                run_md(op, ra, rb, $unsigned($random(seed)) %
                       ((op == MULT || op == MULTU) ? mul_cycles : div_cycles));
            end
        end
        @(posedge clk);
        errors += uut.u_assert.fails;
        $display("%0d checks, %0d errors, %0d of them from assertions",
                 checks, errors, uut.u_assert.fails);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
